// File: src.f
+incdir+src
src/lsPkg.sv
src/lsBuffer.sv
src/lsUnit.sv
src/dataMem.sv
src/lsTop.sv
testbench/lsTop_chk.sv
testbench/lsTop_tb.sv

// File: run.sh
#!/bin/sh
# build and run the load/store testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module lsTop_tb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "test failed" sim.log; then
    exit 1
fi
grep -q "test passed" sim.log

// File: testbench/lsTop_tb.sv
`timescale 1ns/1ns
`include "ls_consts.svh"

module lsTop_tb import lsPkg::*; ();

    logic clk = 1'b0;
    logic rstN, aluWrt, lsEn, bufFree, lsWrt;
    logic [`TAG_W-1:0] aluTag, tagO, tagT, tagW, lsTag;
    logic [`DATA_W-1:0] aluData, operandO, operandT, imm, lsData;
    logic [`NAME_W-1:0] nameW, lsName;
    lsOp_e opCode;

    logic [7:0] refMem [4*`MEM_WORDS];
    logic [15:0] lfsr = 16'd8;
    logic [`TAG_W-1:0] loadTag = 1;
    logic [`TAG_W-1:0] chainTag;
    logic [31:0] expTag[$], expName[$], expData[$];
    int expLat[$], dispQ[$];
    int cyc = 0, bcastCnt = 0, seen;
    string curTest = "reset";
    logic [31:0] addrA, addrB, addrC, val, n;

    lsTop lsTop_i (.*);

    always #10 clk = ~clk;

    // 16-bit Fibonacci LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int cnt);
        logic fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < cnt; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] exp, act);
        assert (exp === act) else begin
            $display("FAILED %s %s: expected %h, actual %h", curTest, what, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("timeout in %s while waiting for %s", curTest, what);
        $display("test failed");
        $fatal(1);
    endtask

    // drives one dispatch on the next edge once the buffer has room
    task automatic dispatch(input lsOp_e op, input logic [31:0] opO, input logic [3:0] tO,
                            input logic [31:0] opT, input logic [31:0] im, input logic aluAlso);
        int waitCnt;
        waitCnt = 0;
        @(posedge clk);
        while (!bufFree) begin
            waitCnt++;
            if (waitCnt > 100) timeoutFail("bufFree");
            @(posedge clk);
        end
        lsEn <= 1'b1;
        opCode <= op;
        operandO <= opO;
        tagO <= tO;
        operandT <= opT;
        tagT <= `TAG_FREE;
        tagW <= loadTag;
        nameW <= n[4:0];
        imm <= im;
        aluWrt <= aluAlso;
        @(posedge clk);
        lsEn <= 1'b0;
        aluWrt <= 1'b0;
    endtask

    task automatic storeOp(input lsOp_e op, input logic [31:0] addr, input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (op == SW || b == 0) refMem[addr + b] = data[8*b +: 8];
        end
        dispatch(op, addr, `TAG_FREE, data, 0, 1'b0);
    endtask

    // expected value follows the reference model at dispatch time
    task automatic loadOp(input lsOp_e op, input logic [31:0] addr, input logic [3:0] tO,
                          input int lat, input logic aluAlso);
        logic [31:0] e;
        e = {refMem[addr+3], refMem[addr+2], refMem[addr+1], refMem[addr]};
        if (op == LB) e = {{24{refMem[addr][7]}}, refMem[addr]};
        loadTag = (loadTag == 7) ? 1 : loadTag + 1;
        n = randBits(5);
        expTag.push_back(loadTag);
        expName.push_back(n);
        expData.push_back(e);
        expLat.push_back(lat);
        dispatch(op, (tO == `TAG_FREE) ? addr : 0, tO, 0, (tO == `TAG_FREE) ? 0 : 8, aluAlso);
    endtask

    task automatic aluBroadcast(input logic [3:0] t, input logic [31:0] d);
        @(posedge clk);
        aluWrt <= 1'b1;
        aluTag <= t;
        aluData <= d;
        @(posedge clk);
        aluWrt <= 1'b0;
    endtask

    task automatic waitDrain();
        int waitCnt;
        waitCnt = 0;
        while (expTag.size() != 0) begin
            waitCnt++;
            if (waitCnt > 200) timeoutFail("load results");
            @(posedge clk);
        end
    endtask

    // compares every broadcast in order with the expected queue
    always @(posedge clk) begin : monitor
        int dc;
        cyc = cyc + 1;
        if (rstN && lsEn && (opCode == LW || opCode == LB)) dispQ.push_back(cyc);
        if (lsWrt) begin
            bcastCnt++;
            assert (expTag.size() != 0) else begin
                $display("unexpected load result in %s", curTest);
                $display("test failed");
                $fatal(1);
            end
            dc = dispQ.pop_front();
            checkValue("tag", expTag.pop_front(), lsTag);
            checkValue("name", expName.pop_front(), lsName);
            checkValue("data", expData.pop_front(), lsData);
            if (expLat[0] >= 0) checkValue("latency", expLat[0], cyc - dc - 1);
            void'(expLat.pop_front());
        end
    end

    initial begin
        {rstN, aluWrt, lsEn, aluTag, tagO, tagT, tagW, nameW} = '0;
        {aluData, operandO, operandT, imm} = '0;
        opCode = LW;
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
            checkValue("bufFree", 1, bufFree);
            checkValue("lsWrt", 0, lsWrt);
            if (i == 3) rstN <= 1'b1;
        end

        curTest = "word store/load";
        addrA = randBits(8);
        addrA = addrA * 4;
        val = randBits(32);
        storeOp(SW, addrA, val);
        loadOp(LW, addrA, `TAG_FREE, 2, 1'b0);
        waitDrain();

        curTest = "byte access";
        val = randBits(8);
        storeOp(SB, addrA + 1, val | 32'h80);
        loadOp(LB, addrA + 1, `TAG_FREE, -1, 1'b0);
        loadOp(LW, addrA, `TAG_FREE, -1, 1'b0);
        waitDrain();

        curTest = "ALU dependence";
        loadOp(LW, addrA, 4'd9, -1, 1'b0);
        seen = bcastCnt;
        repeat (6) @(posedge clk);
        checkValue("early broadcasts", 0, bcastCnt - seen);
        aluBroadcast(4'd9, addrA - 8);
        waitDrain();
        aluTag <= 4'd10;
        aluData <= addrA - 8;
        loadOp(LB, addrA, 4'd10, -1, 1'b1);
        waitDrain();

        curTest = "fill and order";
        addrB = randBits(8);
        addrB = addrB * 4;
        loadOp(LW, addrA, 4'd11, -1, 1'b0);
        val = randBits(32);
        storeOp(SW, addrB, val);
        loadOp(LW, addrB, `TAG_FREE, -1, 1'b0);
        val = randBits(8);
        storeOp(SB, addrB + 3, val);
        loadOp(LB, addrB + 3, `TAG_FREE, -1, 1'b0);
        loadOp(LW, addrB, `TAG_FREE, -1, 1'b0);
        val = randBits(8);
        storeOp(SB, addrB + 2, val);
        loadOp(LW, addrB, `TAG_FREE, -1, 1'b0);
        @(posedge clk);
        checkValue("bufFree when full", 0, bufFree);
        aluBroadcast(4'd11, addrA - 8);
        waitDrain();

        curTest = "load chaining";
        addrC = randBits(8);
        addrC = addrC * 4;
        // pointer word and target word must not overlap
        if (addrC == addrB) addrC = addrC ^ 32'h4;
        storeOp(SW, addrB, addrC);
        val = randBits(32);
        storeOp(SW, addrC, val);
        loadOp(LW, addrB, `TAG_FREE, -1, 1'b0);
        // base of the next load is the previous load's result
        chainTag = loadTag;
        loadTag = (loadTag == 7) ? 1 : loadTag + 1;
        expTag.push_back(loadTag);
        n = randBits(5);
        expName.push_back(n);
        expData.push_back(val);
        expLat.push_back(-1);
        dispatch(LW, 0, chainTag, 0, 0, 1'b0);
        waitDrain();
        $display("test passed");
        $finish;
    end

endmodule

// File: testbench/lsTop_chk.sv
`timescale 1ns/1ns
`include "ls_consts.svh"

module lsTop_chk (
    input logic                clk,
    input logic                rstN,
    input logic                lsEn,
    input logic                bufFree,
    input logic                lsWrt,
    input logic [`TAG_W-1:0]   lsTag
);

    // set by the first dispatch after reset
    logic seenDisp;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            seenDisp <= 1'b0;
        end else if (lsEn) begin
            seenDisp <= 1'b1;
        end
    end

    dispatchWhenFree: assert property (@(posedge clk) disable iff (!rstN)
        lsEn |-> bufFree)
        else $error("dispatch while the buffer is full");

    resultTagValid: assert property (@(posedge clk) disable iff (!rstN)
        lsWrt |-> (lsTag != `TAG_FREE))
        else $error("load result carries the free tag");

    noRepeatedTag: assert property (@(posedge clk) disable iff (!rstN)
        (lsWrt && $past(lsWrt)) |-> (lsTag != $past(lsTag)))
        else $error("load result repeated with the same tag");

    quietBeforeDispatch: assert property (@(posedge clk) disable iff (!rstN)
        !seenDisp |-> !lsWrt)
        else $error("load result before any dispatch");

endmodule

bind lsTop lsTop_chk lsTop_chk_i (.*);

// File: src/lsTop.sv
`timescale 1ns/1ns
`include "ls_consts.svh"

module lsTop
    import lsPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    // ALU result bus
    input  logic                 aluWrt,
    input  logic [`TAG_W-1:0]    aluTag,
    input  logic [`DATA_W-1:0]   aluData,
    // dispatch
    input  logic                 lsEn,
    input  lsOp_e                opCode,
    input  logic [`DATA_W-1:0]   operandO,
    input  logic [`DATA_W-1:0]   operandT,
    input  logic [`TAG_W-1:0]    tagO,
    input  logic [`TAG_W-1:0]    tagT,
    input  logic [`TAG_W-1:0]    tagW,
    input  logic [`NAME_W-1:0]   nameW,
    input  logic [`DATA_W-1:0]   imm,
    output logic                 bufFree,
    // load result bus
    output logic                 lsWrt,
    output logic [`TAG_W-1:0]    lsTag,
    output logic [`NAME_W-1:0]   lsName,
    output logic [`DATA_W-1:0]   lsData
);

    // buffer to unit
    logic                issueEn;
    lsOp_e               issueOp;
    logic [`DATA_W-1:0]  issueBase;
    logic [`DATA_W-1:0]  issueStData;
    logic [`DATA_W-1:0]  issueImm;
    logic [`TAG_W-1:0]   issueTag;
    logic [`NAME_W-1:0]  issueName;

    // unit to memory
    logic                memEn;
    logic [3:0]          memWe;
    logic [`MEM_AW-1:0]  memAddr;
    memWord_u            memWData;
    memWord_u            memRData;

    // load results also go back to the buffer for snooping
    lsBuffer lsBuffer_i (
        .clk, .rstN,
        .aluWrt, .aluTag, .aluData,
        .lsWrt, .lsTag, .lsData,
        .lsEn, .opCode, .operandO, .operandT, .tagO, .tagT, .tagW, .nameW, .imm,
        .issueEn, .issueOp, .issueBase, .issueStData, .issueImm, .issueTag,
        .issueName, .bufFree
    );

    lsUnit lsUnit_i (
        .clk, .rstN,
        .issueEn, .issueOp, .issueBase, .issueStData, .issueImm, .issueTag,
        .issueName,
        .memEn, .memWe, .memAddr, .memWData, .memRData,
        .lsWrt, .lsTag, .lsName, .lsData
    );

    dataMem dataMem_i (
        .clk, .memEn, .memWe, .memAddr, .memWData, .memRData
    );

endmodule

// File: src/dataMem.sv
`timescale 1ns/1ns
`include "ls_consts.svh"

module dataMem
    import lsPkg::*;
(
    input  logic                clk,
    input  logic                memEn,
    input  logic [3:0]          memWe,
    input  logic [`MEM_AW-1:0]  memAddr,
    input  memWord_u            memWData,
    output memWord_u            memRData
);

    memWord_u mem [`MEM_WORDS];

    // single port; a write returns the word as it was before
    always_ff @(posedge clk) begin
        if (memEn) begin
            for (int b = 0; b < 4; b++) begin
                // byte lanes written independently
                if (memWe[b]) begin
                    mem[memAddr].bytes[b] <= memWData.bytes[b];
                end
            end
            memRData <= mem[memAddr];
        end
    end

endmodule

// File: src/lsUnit.sv
`timescale 1ns/1ns
`include "ls_consts.svh"

module lsUnit
    import lsPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    // issue from the buffer
    input  logic                 issueEn,
    input  lsOp_e                issueOp,
    input  logic [`DATA_W-1:0]   issueBase,
    input  logic [`DATA_W-1:0]   issueStData,
    input  logic [`DATA_W-1:0]   issueImm,
    input  logic [`TAG_W-1:0]    issueTag,
    input  logic [`NAME_W-1:0]   issueName,
    // data memory
    output logic                 memEn,
    output logic [3:0]           memWe,
    output logic [`MEM_AW-1:0]   memAddr,
    output memWord_u             memWData,
    input  memWord_u             memRData,
    // load result bus
    output logic                 lsWrt,
    output logic [`TAG_W-1:0]    lsTag,
    output logic [`NAME_W-1:0]   lsName,
    output logic [`DATA_W-1:0]   lsData
);

    logic [`DATA_W-1:0]  byteAddr;
    logic [1:0]          byteOff;
    logic                isStore;
    logic                isByte;

    // load stage, lines up with the registered memory read
    logic                ldValid;
    logic [`TAG_W-1:0]   ldTag;
    logic [`NAME_W-1:0]  ldName;
    logic [1:0]          ldOff;
    logic                ldByte;
    logic [7:0]          ldByteVal;

    // address stage
    assign byteAddr = issueBase + issueImm;
    assign byteOff  = byteAddr[1:0];
    assign isStore  = (issueOp == SW) || (issueOp == SB);
    assign isByte   = (issueOp == LB) || (issueOp == SB);

    assign memEn   = issueEn;
    assign memAddr = byteAddr[`MEM_AW+1:2];

    always_comb begin
        memWe = 4'b0000;
        if (issueEn && isStore) begin
            memWe = isByte ? (4'b0001 << byteOff) : 4'b1111;
        end
    end

    // byte stores put the byte in every lane, the enable picks one
    assign memWData.word = isByte ? {4{issueStData[7:0]}} : issueStData;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ldValid <= 1'b0;
            ldTag   <= `TAG_FREE;
        end else begin
            ldValid <= issueEn && !isStore;
            if (issueEn && !isStore) begin
                ldTag <= issueTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueEn && !isStore) begin
            ldName <= issueName;
            ldOff  <= byteOff;
            ldByte <= isByte;
        end
    end

    // result stage
    assign ldByteVal = memRData.bytes[ldOff];

    assign lsWrt  = ldValid;
    assign lsTag  = ldTag;
    assign lsName = ldName;
    assign lsData = ldByte ? {{(`DATA_W-8){ldByteVal[7]}}, ldByteVal} : memRData.word;

endmodule

// File: src/lsBuffer.sv
`timescale 1ns/1ns
`include "ls_consts.svh"

module lsBuffer
    import lsPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    // ALU result bus
    input  logic                 aluWrt,
    input  logic [`TAG_W-1:0]    aluTag,
    input  logic [`DATA_W-1:0]   aluData,
    // load result bus, fed back from the unit
    input  logic                 lsWrt,
    input  logic [`TAG_W-1:0]    lsTag,
    input  logic [`DATA_W-1:0]   lsData,
    // dispatch
    input  logic                 lsEn,
    input  lsOp_e                opCode,
    input  logic [`DATA_W-1:0]   operandO,
    input  logic [`DATA_W-1:0]   operandT,
    input  logic [`TAG_W-1:0]    tagO,
    input  logic [`TAG_W-1:0]    tagT,
    input  logic [`TAG_W-1:0]    tagW,
    input  logic [`NAME_W-1:0]   nameW,
    input  logic [`DATA_W-1:0]   imm,
    // issue to the load/store unit
    output logic                 issueEn,
    output lsOp_e                issueOp,
    output logic [`DATA_W-1:0]   issueBase,
    output logic [`DATA_W-1:0]   issueStData,
    output logic [`DATA_W-1:0]   issueImm,
    output logic [`TAG_W-1:0]    issueTag,
    output logic [`NAME_W-1:0]   issueName,
    output logic                 bufFree
);

    // entry storage
    logic [`RS_SIZE-1:0]   entValid;
    lsOp_e                 entOp    [`RS_SIZE];
    logic [`DATA_W-1:0]    entDataO [`RS_SIZE];
    logic [`DATA_W-1:0]    entDataT [`RS_SIZE];
    logic [`TAG_W-1:0]     entTagO  [`RS_SIZE];
    logic [`TAG_W-1:0]     entTagT  [`RS_SIZE];
    logic [`DATA_W-1:0]    entImm   [`RS_SIZE];
    logic [`TAG_W-1:0]     entTagW  [`RS_SIZE];
    logic [`NAME_W-1:0]    entName  [`RS_SIZE];

    // head is the oldest entry, tail the next free slot
    logic [`RS_PTR_W-1:0]  head;
    logic [`RS_PTR_W-1:0]  tail;
    logic [`RS_PTR_W:0]    count;

    logic                  pop;

    // resolve one operand against both result buses
    // returns {tag, data}; a pending tag that matches a strobed bus
    // becomes free and takes that bus's data
    function automatic logic [`TAG_W+`DATA_W-1:0] snoopOperand(
        input logic [`TAG_W-1:0]  tag,
        input logic [`DATA_W-1:0] data
    );
        logic [`TAG_W+`DATA_W-1:0] res;
        res = {tag, data};
        if (tag != `TAG_FREE) begin
            if (aluWrt && (aluTag == tag)) begin
                res = {`TAG_FREE, aluData};
            end else if (lsWrt && (lsTag == tag)) begin
                res = {`TAG_FREE, lsData};
            end
        end
        return res;
    endfunction

    // head may leave once both its operands are present
    assign pop = entValid[head] && (entTagO[head] == `TAG_FREE) &&
                 (entTagT[head] == `TAG_FREE);

    assign bufFree = (count < `RS_SIZE);

    // valid bits, pointers and occupancy
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entValid <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (pop) begin
                entValid[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            if (lsEn) begin
                entValid[tail] <= 1'b1;
                tail           <= tail + 1'b1;
            end
            case ({lsEn, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // operand snooping and dispatch write
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (entValid[i]) begin
                {entTagO[i], entDataO[i]} <= snoopOperand(entTagO[i], entDataO[i]);
                {entTagT[i], entDataT[i]} <= snoopOperand(entTagT[i], entDataT[i]);
            end
        end
        // new entry sees this edge's broadcasts too
        if (lsEn) begin
            entOp[tail]                     <= opCode;
            {entTagO[tail], entDataO[tail]} <= snoopOperand(tagO, operandO);
            {entTagT[tail], entDataT[tail]} <= snoopOperand(tagT, operandT);
            entImm[tail]                    <= imm;
            entTagW[tail]                   <= tagW;
            entName[tail]                   <= nameW;
        end
    end

    // issue strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            issueEn <= 1'b0;
        end else begin
            issueEn <= pop;
        end
    end

    // issue payload, only meaningful with issueEn
    always_ff @(posedge clk) begin
        if (pop) begin
            issueOp     <= entOp[head];
            issueBase   <= entDataO[head];
            issueStData <= entDataT[head];
            issueImm    <= entImm[head];
            issueTag    <= entTagW[head];
            issueName   <= entName[head];
        end
    end

endmodule

// File: src/lsPkg.sv
`include "ls_consts.svh"

package lsPkg;

    // load/store operations
    // an empty slot is marked by its valid bit, not by an opcode
    typedef enum logic [1:0] {
        LW = 2'd0,
        LB = 2'd1,
        SW = 2'd2,
        SB = 2'd3
    } lsOp_e;

    // one memory word, seen whole or as four byte lanes
    // lane 0 holds the lowest byte address (little endian)
    typedef union packed {
        logic [`DATA_W-1:0]    word;
        logic [3:0][7:0]       bytes;
    } memWord_u;

endpackage

// File: src/ls_consts.svh
`ifndef LS_CONSTS_SVH
`define LS_CONSTS_SVH

// operand and memory word width
`define DATA_W      32

// reservation tags, zero means the operand value is present
`define TAG_W       4
`define TAG_FREE    {`TAG_W{1'b0}}

// architectural register name
`define NAME_W      5

// load/store buffer depth, RS_SIZE must equal 2**RS_PTR_W
`define RS_SIZE     8
`define RS_PTR_W    3

// data memory, word addressed
`define MEM_WORDS   256
`define MEM_AW      8

`endif
